// ==== project.f ====
hdl/gfxPkg.sv
hdl/frameBufferIf.sv
hdl/hostRegs.sv
hdl/drawSequencer.sv
hdl/frameBufferPort.sv
hdl/gfxController.sv
sim/sramModel.sv
sim/tbGfxController.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tbGfxController -f project.f
	./obj_dir/VtbGfxController | tee sim.log
	grep -qx "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tbGfxController.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbGfxController import gfxPkg::*; ();

	localparam int xBits     = 10;
	localparam int yBits     = 9;
	localparam int addrBits  = xBits - 1 + yBits;
	localparam int clkPeriod = 10;

	////////////////////////////////////////
	// cycle budget of the tests
	////////////////////////////////////////

	localparam int resetCycles   = 16;
	localparam int pixelCycles   = 4 * 60;		// four put pixels each read back twice
	localparam int lineCycles    = 4 * 20 * 22;	// four lines of up to 16 pixels plus neighbours
	localparam int paletteCycles = 120;
	localparam int strobeCycles  = 150;
	localparam int testCycles    = resetCycles + pixelCycles + lineCycles + paletteCycles +
		strobeCycles;

	logic     Clk;
	logic     rst;
	busWord_t AddressIn;
	busWord_t DataInFromCPU;
	logic     AS_L;
	logic     UDS_L;
	logic     LDS_L;
	logic     RW;
	logic     GraphicsCS_L;
	logic     VSync_L;
	busWord_t SRam_DataIn;
	busWord_t DataOutToCPU;
	logic [addrBits-1:0] Sram_AddressOut;
	busWord_t Sram_DataOut;
	logic     Sram_UDS_Out_L;
	logic     Sram_LDS_Out_L;
	logic     Sram_RW_Out;
	logic [paletteAddrBits-1:0] ColourPaletteAddr;
	logic [paletteDataBits-1:0] ColourPaletteData;
	logic     ColourPalette_WE_H;

	busWord_t shadow [0:(1<<addrBits)-1];	// expected frame buffer contents
	logic [15:0] lfsrState;
	int mismatchCount = 0;
	int otherCount    = 0;
	int weCount       = 0;			// palette write enable pulses seen
	logic [paletteAddrBits-1:0] weAddr;
	logic [paletteDataBits-1:0] weData;

	gfxController #(.xBits(xBits), .yBits(yBits)) u_gfxController (
		.Clk               (Clk),
		.rst               (rst),
		.AddressIn         (AddressIn),
		.DataInFromCPU     (DataInFromCPU),
		.AS_L              (AS_L),
		.UDS_L             (UDS_L),
		.LDS_L             (LDS_L),
		.RW                (RW),
		.GraphicsCS_L      (GraphicsCS_L),
		.VSync_L           (VSync_L),
		.SRam_DataIn       (SRam_DataIn),
		.DataOutToCPU      (DataOutToCPU),
		.Sram_AddressOut   (Sram_AddressOut),
		.Sram_DataOut      (Sram_DataOut),
		.Sram_UDS_Out_L    (Sram_UDS_Out_L),
		.Sram_LDS_Out_L    (Sram_LDS_Out_L),
		.Sram_RW_Out       (Sram_RW_Out),
		.ColourPaletteAddr (ColourPaletteAddr),
		.ColourPaletteData (ColourPaletteData),
		.ColourPalette_WE_H(ColourPalette_WE_H)
	);

	sramModel #(.addrBits(addrBits)) u_sramModel (
		.Clk      (Clk),
		.address  (Sram_AddressOut),
		.writeData(Sram_DataOut),
		.upperL   (Sram_UDS_Out_L),
		.lowerL   (Sram_LDS_Out_L),
		.readWrite(Sram_RW_Out),
		.readData (SRam_DataIn)
	);

	always #(clkPeriod / 2) Clk = ~Clk;

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// word address is y followed by x without its low bit
	function automatic logic [addrBits-1:0] pixelAddr(
		input busWord_t x,
		input busWord_t y
	);
		return {y[yBits-1:0], x[xBits-1:1]};
	endfunction

	// same fill as the SRAM
	function automatic busWord_t fillWord(input logic [addrBits-1:0] a);
		logic [31:0] p;
		p = a * 32'd40503;
		return p[15:0] ^ a[addrBits-1:2];
	endfunction

	function automatic logic [7:0] expectedPixel(input busWord_t x, input busWord_t y);
		busWord_t w;
		w = shadow[pixelAddr(x, y)];
		return x[0] ? w[7:0] : w[15:8];	// even x sits in the upper byte
	endfunction

	function automatic void setShadow(
		input busWord_t   x,
		input busWord_t   y,
		input logic [7:0] b
	);
		logic [addrBits-1:0] a;
		a = pixelAddr(x, y);
		if (x[0])
			shadow[a][7:0] = b;
		else
			shadow[a][15:8] = b;
	endfunction

	// Galois LFSR stepped once for each bit handed out
	function automatic busWord_t randomBits(input int n);
		busWord_t r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			r = {r[14:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
		end
		return r;
	endfunction

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic checkWord(input string name, input busWord_t got, input busWord_t want);
		if (got !== want) begin
			mismatchCount++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic want);
		if (got !== want) begin
			mismatchCount++;
			$display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, want);
		end
	endtask

	task automatic checkPalette(
		input logic [paletteAddrBits-1:0] gotAddr,
		input logic [paletteAddrBits-1:0] wantAddr,
		input logic [paletteDataBits-1:0] gotData,
		input logic [paletteDataBits-1:0] wantData
	);
		if (gotAddr !== wantAddr) begin
			mismatchCount++;
			$display("mismatch at %0t ns: ColourPaletteAddr got %h expected %h", $time,
				gotAddr, wantAddr);
		end
		if (gotData !== wantData) begin
			mismatchCount++;
			$display("mismatch at %0t ns: ColourPaletteData got %h expected %h", $time,
				gotData, wantData);
		end
	endtask

	////////////////////////////////////////
	// CPU bus tasks
	////////////////////////////////////////

	// one bus cycle holding AS_L low across a single rising edge
	task automatic writeReg(input logic [6:0] offset, input busWord_t data,
			input logic upperL = 1'b0, input logic lowerL = 1'b0);
		@(posedge Clk);
		#1;
		AddressIn     = {8'h00, offset, 1'b0};
		DataInFromCPU = data;
		RW            = 1'b0;
		UDS_L         = upperL;
		LDS_L         = lowerL;
		GraphicsCS_L  = 1'b0;
		AS_L          = 1'b0;
		@(posedge Clk);
		#1;
		AS_L         = 1'b1;	// releasing the strobe lets a command start
		UDS_L        = 1'b1;
		LDS_L        = 1'b1;
		GraphicsCS_L = 1'b1;
		RW           = 1'b1;
	endtask

	task automatic readReg(input logic [6:0] offset, output busWord_t data);
		@(posedge Clk);
		#1;
		AddressIn    = {8'h00, offset, 1'b0};
		RW           = 1'b1;
		UDS_L        = 1'b0;
		LDS_L        = 1'b0;
		GraphicsCS_L = 1'b0;
		AS_L         = 1'b0;
		@(negedge Clk);
		data = DataOutToCPU;	// read data is combinational and has settled by mid cycle
		@(posedge Clk);
		#1;
		AS_L         = 1'b1;
		UDS_L        = 1'b1;
		LDS_L        = 1'b1;
		GraphicsCS_L = 1'b1;
	endtask

	task automatic waitIdle();
		busWord_t status;
		int polls;
		repeat (2) @(posedge Clk);	// status goes busy two edges after the strobe ends
		polls = 0;
		readReg(regCommandOffset, status);
		while (!status[0] && polls < 200) begin
			polls++;
			readReg(regCommandOffset, status);
		end
		if (!status[0]) begin
			otherCount++;
			$display("error at %0t ns: controller still busy after %0d status polls",
				$time, polls);
		end
	endtask

	task automatic putPixelCpu(input busWord_t x, input busWord_t y, input busWord_t col);
		writeReg(regX1Offset, x);
		writeReg(regY1Offset, y);
		writeReg(regColourOffset, col);
		writeReg(regCommandOffset, putPixel);
		waitIdle();
		setShadow(x, y, col[7:0]);
	endtask

	// get pixel then compare the colour latch with the shadow
	task automatic checkPixel(input busWord_t x, input busWord_t y);
		busWord_t got;
		writeReg(regX1Offset, x);
		writeReg(regY1Offset, y);
		writeReg(regCommandOffset, getPixel);
		waitIdle();
		readReg(regColourOffset, got);
		checkWord($sformatf("colour latch at x %0d y %0d", x, y), got,
			{8'h00, expectedPixel(x, y)});
	endtask

	task automatic lineTest(input logic vertical, input busWord_t c1, input busWord_t c2,
			input busWord_t fixed, input busWord_t col);
		busWord_t pos;
		busWord_t lo;
		busWord_t hi;
		writeReg(vertical ? regX1Offset : regY1Offset, fixed);
		writeReg(vertical ? regY1Offset : regX1Offset, c1);
		writeReg(vertical ? regY2Offset : regX2Offset, c2);
		writeReg(regColourOffset, col);
		writeReg(regCommandOffset, vertical ? vLine : hLine);
		waitIdle();
		// the first coordinate is always drawn and the line steps up to the second inclusive
		pos = c1;
		setShadow(vertical ? fixed : pos, vertical ? pos : fixed, col[7:0]);
		while (pos < c2) begin
			pos++;
			setShadow(vertical ? fixed : pos, vertical ? pos : fixed, col[7:0]);
		end
		lo = ((c1 < c2) ? c1 : c2) - 16'd1;	// one neighbour on each side
		hi = ((c1 > c2) ? c1 : c2) + 16'd1;
		for (pos = lo; pos <= hi; pos++)
			checkPixel(vertical ? fixed : pos, vertical ? pos : fixed);
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	always @(negedge Clk) begin
		if (ColourPalette_WE_H) begin
			weCount++;
			weAddr = ColourPaletteAddr;
			weData = ColourPaletteData;
		end
	end

	initial begin
		busWord_t rd;
		busWord_t px;
		busWord_t py;
		busWord_t col;
		busWord_t c1;
		busWord_t c2;
		busWord_t wrongX;
		int k;
		Clk           = 1'b0;
		rst           = 1'b1;
		AddressIn     = '0;
		DataInFromCPU = '0;
		AS_L          = 1'b1;
		UDS_L         = 1'b1;
		LDS_L         = 1'b1;
		RW            = 1'b1;
		GraphicsCS_L  = 1'b1;
		VSync_L       = 1'b1;	// sync inactive until the palette test
		lfsrState     = 16'd9394;
		for (k = 0; k < (1 << addrBits); k++)
			shadow[k] = fillWord(k[addrBits-1:0]);
		repeat (resetCycles) @(posedge Clk);
		#1;
		rst = 1'b0;

		// state after reset
		readReg(regCommandOffset, rd);
		checkWord("status after reset", rd, 16'h0001);
		@(negedge Clk);
		checkBit("ColourPalette_WE_H", ColourPalette_WE_H, 1'b0);
		checkBit("Sram_UDS_Out_L", Sram_UDS_Out_L, 1'b1);
		checkBit("Sram_LDS_Out_L", Sram_LDS_Out_L, 1'b1);
		checkBit("Sram_RW_Out", Sram_RW_Out, 1'b1);

		// put pixel at even and odd x and the partner byte must survive
		for (k = 0; k < 4; k++) begin
			px    = randomBits(9) << 1;
			px[0] = k[0];
			py    = randomBits(9);
			col   = randomBits(16);
			putPixelCpu(px, py, col);
			checkPixel(px, py);
			checkPixel(px ^ 16'd1, py);
		end

		c1 = randomBits(9) + 16'd16;		// horizontal and forward
		c2 = c1 + randomBits(4);
		lineTest(1'b0, c1, c2, randomBits(9), randomBits(16));
		c1 = randomBits(9) + 16'd16;		// reversed so only x1 is drawn
		c2 = c1 - 16'd1 - randomBits(3);
		lineTest(1'b0, c1, c2, randomBits(9), randomBits(16));
		c1 = randomBits(8) + 16'd16;
		c2 = c1 + randomBits(4);
		lineTest(1'b1, c1, c2, randomBits(10), randomBits(16));
		c1 = randomBits(8) + 16'd16;
		c2 = c1 - 16'd1 - randomBits(3);
		lineTest(1'b1, c1, c2, randomBits(10), randomBits(16));

		// palette write is held off while VSync_L is high
		px  = randomBits(16);
		py  = randomBits(16);
		col = randomBits(16);
		writeReg(regX1Offset, px);
		writeReg(regY1Offset, py);
		writeReg(regColourOffset, col);
		writeReg(regCommandOffset, programPalette);
		repeat (20) @(posedge Clk);
		checkWord("palette write count", 16'(weCount), 16'd0);
		readReg(regCommandOffset, rd);
		checkWord("status while waiting for sync", rd, 16'h0000);
		VSync_L = 1'b0;
		waitIdle();
		VSync_L = 1'b1;
		checkWord("palette write count", 16'(weCount), 16'd1);
		checkPalette(weAddr, col[5:0], weData, {px[7:0], py});

		// only the lower lane is written so the upper byte of X1 keeps its old value
		px = randomBits(10) | 16'h0100;
		writeReg(regX1Offset, px);
		rd        = randomBits(8);
		rd[15:8]  = px[15:8] ^ 8'h02;
		writeReg(regX1Offset, rd, 1'b1, 1'b0);
		px     = {px[15:8], rd[7:0]};
		wrongX = rd;
		py     = randomBits(9);
		col    = randomBits(16);
		writeReg(regY1Offset, py);
		writeReg(regColourOffset, col);
		writeReg(regCommandOffset, putPixel);
		waitIdle();
		setShadow(px, py, col[7:0]);
		checkPixel(px, py);
		checkPixel(wrongX, py);

		$display("summary: %0d mismatches, %0d other errors", mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// watchdog with four times the expected run length
	initial begin
		#(testCycles * 4 * clkPeriod);
		otherCount++;
		$display("error at %0t ns: watchdog expired before the tests finished", $time);
		$display("summary: %0d mismatches, %0d other errors", mismatchCount, otherCount);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/sramModel.sv ====
`timescale 1ns/1ns
`default_nettype none

module sramModel #(
	parameter int addrBits = 18
) (
	input  logic                Clk,
	input  logic [addrBits-1:0] address,
	input  logic [15:0]         writeData,
	input  logic                upperL,		// upper byte lane, active low
	input  logic                lowerL,		// lower byte lane, active low
	input  logic                readWrite,	// high reads, low writes
	output logic [15:0]         readData
);

	logic [15:0] mem [0:(1<<addrBits)-1];

	// every word starts with its own value so a misplaced access shows up
	function automatic logic [15:0] fillWord(input logic [addrBits-1:0] a);
		logic [31:0] p;
		p = a * 32'd40503;
		return p[15:0] ^ a[addrBits-1:2];	// the shift pulls in the top address bits
	endfunction

	initial begin
		int i;
		for (i = 0; i < (1 << addrBits); i++)
			mem[i] = fillWord(i[addrBits-1:0]);
	end

	// one access per edge, data is on readData from the edge after the request
	always @(posedge Clk) begin
		if (!readWrite) begin
			if (!upperL)
				mem[address][15:8] = writeData[15:8];
			if (!lowerL)
				mem[address][7:0] = writeData[7:0];
		end else if (!upperL || !lowerL) begin
			readData <= mem[address];	// a read with both strobes high is no access
		end
	end

endmodule

`default_nettype wire

// ==== hdl/gfxController.sv ====
`timescale 1ns/1ns
`default_nettype none

module gfxController import gfxPkg::*; #(
	parameter int xBits = 10,	// 1024 pixels across
	parameter int yBits = 9		// 512 lines down
) (
	input  logic     Clk,
	input  logic     rst,
	input  busWord_t AddressIn,
	input  busWord_t DataInFromCPU,
	input  logic     AS_L,
	input  logic     UDS_L,
	input  logic     LDS_L,
	input  logic     RW,
	input  logic     GraphicsCS_L,
	input  logic     VSync_L,
	input  busWord_t SRam_DataIn,
	output busWord_t DataOutToCPU,
	output logic [xBits+yBits-2:0] Sram_AddressOut,
	output busWord_t Sram_DataOut,
	output logic     Sram_UDS_Out_L,
	output logic     Sram_LDS_Out_L,
	output logic     Sram_RW_Out,
	output logic [paletteAddrBits-1:0] ColourPaletteAddr,
	output logic [paletteDataBits-1:0] ColourPaletteData,
	output logic     ColourPalette_WE_H
);

	// register values seen by the sequencer
	busWord_t   x1;
	busWord_t   y1;
	busWord_t   x2;
	busWord_t   y2;
	busWord_t   colour;
	gfxCmd_t    cmd;
	logic       cmdStart;
	logic       idle;
	logic       latchLoad;		// get pixel result back to the register block
	logic [7:0] latchByte;

	// requests from the sequencer to the SRAM port
	frameBufferIf #(.xBits(xBits), .yBits(yBits)) fbBus ();

	hostRegs u_hostRegs (
		.Clk          (Clk),
		.rst          (rst),
		.AddressIn    (AddressIn),
		.DataInFromCPU(DataInFromCPU),
		.AS_L         (AS_L),
		.UDS_L        (UDS_L),
		.LDS_L        (LDS_L),
		.RW           (RW),
		.GraphicsCS_L (GraphicsCS_L),
		.idle         (idle),
		.latchLoad    (latchLoad),
		.latchByte    (latchByte),
		.DataOutToCPU (DataOutToCPU),
		.x1           (x1),
		.y1           (y1),
		.x2           (x2),
		.y2           (y2),
		.colour       (colour),
		.cmd          (cmd),
		.cmdStart     (cmdStart)
	);

	drawSequencer #(.xBits(xBits), .yBits(yBits)) u_drawSequencer (
		.Clk               (Clk),
		.rst               (rst),
		.x1                (x1),
		.y1                (y1),
		.x2                (x2),
		.y2                (y2),
		.colour            (colour),
		.cmd               (cmd),
		.cmdStart          (cmdStart),
		.VSync_L           (VSync_L),
		.fb                (fbBus.seq),
		.idle              (idle),
		.latchLoad         (latchLoad),
		.latchByte         (latchByte),
		.ColourPaletteAddr (ColourPaletteAddr),
		.ColourPaletteData (ColourPaletteData),
		.ColourPalette_WE_H(ColourPalette_WE_H)
	);

	frameBufferPort #(.xBits(xBits), .yBits(yBits)) u_frameBufferPort (
		.Clk            (Clk),
		.rst            (rst),
		.SRam_DataIn    (SRam_DataIn),
		.fb             (fbBus.port),
		.Sram_AddressOut(Sram_AddressOut),
		.Sram_DataOut   (Sram_DataOut),
		.Sram_UDS_Out_L (Sram_UDS_Out_L),
		.Sram_LDS_Out_L (Sram_LDS_Out_L),
		.Sram_RW_Out    (Sram_RW_Out)
	);

endmodule

`default_nettype wire

// ==== hdl/frameBufferPort.sv ====
`timescale 1ns/1ns
`default_nettype none

module frameBufferPort import gfxPkg::*; #(
	parameter int xBits = 10,
	parameter int yBits = 9
) (
	input  logic     Clk,
	input  logic     rst,
	input  busWord_t SRam_DataIn,
	frameBufferIf.port fb,
	output logic [xBits+yBits-2:0] Sram_AddressOut,
	output busWord_t Sram_DataOut,
	output logic     Sram_UDS_Out_L,
	output logic     Sram_LDS_Out_L,
	output logic     Sram_RW_Out
);

	logic [1:0] rdPend;		// read in flight, one bit per cycle of SRAM latency
	logic [1:0] selUpper;	// byte choice travelling with each access

	////////////////////////////////////////
	// SRAM pin register
	////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (rst) begin
			Sram_UDS_Out_L <= 1'b1;
			Sram_LDS_Out_L <= 1'b1;
			Sram_RW_Out    <= 1'b1;
			rdPend         <= 2'b00;
			fb.rdValid     <= 1'b0;
		end else begin
			// a read enables both lanes and the byte is picked on return
			Sram_UDS_Out_L <= !(fb.reqValid && (fb.reqUpper || !fb.reqWrite));
			Sram_LDS_Out_L <= !(fb.reqValid && (fb.reqLower || !fb.reqWrite));
			Sram_RW_Out    <= !(fb.reqValid && fb.reqWrite);	// rests in read
			rdPend         <= {rdPend[0], fb.reqValid && !fb.reqWrite};
			fb.rdValid     <= rdPend[1];	// data has been on SRam_DataIn for a cycle
		end
	end

	// address and data only matter while a strobe is low
	always_ff @(posedge Clk) begin
		Sram_AddressOut <= fb.reqAddr;
		Sram_DataOut    <= fb.reqData;
		selUpper        <= {selUpper[0], fb.reqUpper};
		fb.rdByte       <= selUpper[1] ? SRam_DataIn[15:8] : SRam_DataIn[7:0];
	end

endmodule

`default_nettype wire

// ==== hdl/drawSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module drawSequencer import gfxPkg::*; #(
	parameter int xBits = 10,
	parameter int yBits = 9
) (
	input  logic     Clk,
	input  logic     rst,
	input  busWord_t x1,
	input  busWord_t y1,
	input  busWord_t x2,
	input  busWord_t y2,
	input  busWord_t colour,
	input  gfxCmd_t  cmd,
	input  logic     cmdStart,
	input  logic     VSync_L,
	frameBufferIf.seq fb,
	output logic     idle,
	output logic     latchLoad,
	output logic [7:0] latchByte,
	output logic [paletteAddrBits-1:0] ColourPaletteAddr,
	output logic [paletteDataBits-1:0] ColourPaletteData,
	output logic     ColourPalette_WE_H
);

	seqState_t        state;
	logic [xBits-1:0] xCnt;			// working x, the CPU copy in hostRegs is left alone
	logic [yBits-1:0] yCnt;			// working y
	logic [xBits-1:0] xEnd;			// last x of a horizontal line
	logic [yBits-1:0] yEnd;			// last y of a vertical line
	logic [7:0]       pixByte;		// colour byte captured at the start of the command
	logic             lineVertical;	// the line steps along y instead of x
	logic             lineDone;		// the current pixel is the last one of the line

	// a start beyond the end also counts as done, so only that first pixel is drawn
	assign lineDone = lineVertical ? (yCnt >= yEnd) : (xCnt >= xEnd);

	////////////////////////////////////////
	// command FSM
	////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (rst) begin
			state              <= stateIdle;
			idle               <= 1'b1;
			ColourPalette_WE_H <= 1'b0;
		end else begin
			ColourPalette_WE_H <= 1'b0;					// the write enable only ever pulses
			idle <= (state == stateIdle) && !cmdStart;	// drops as the command is taken
			case (state)
				stateIdle: begin
					if (cmdStart)
						state <= stateDispatch;
				end
				stateDispatch: begin
					case (cmd)
						putPixel:       state <= stateWritePixel;
						getPixel:       state <= stateReadIssue;
						hLine:          state <= stateDrawLine;
						vLine:          state <= stateDrawLine;
						programPalette: state <= statePaletteWait;
						default:        state <= stateIdle;	// unknown command does nothing
					endcase
				end
				stateWritePixel: state <= stateIdle;		// one access is enough
				stateDrawLine: begin
					if (lineDone)
						state <= stateIdle;
				end
				stateReadIssue: state <= stateReadWait;
				stateReadWait: begin
					if (fb.rdValid)
						state <= stateIdle;	// latch loads on this same edge
				end
				statePaletteWait: begin
					// change the palette only while the display is blanked
					if (!VSync_L) begin
						ColourPalette_WE_H <= 1'b1;
						state              <= stateIdle;
					end
				end
				default: state <= stateIdle;
			endcase
		end
	end

	////////////////////////////////////////
	// coordinate counters and palette data
	////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if ((state == stateIdle) && cmdStart) begin
			xCnt    <= x1[xBits-1:0];
			yCnt    <= y1[yBits-1:0];
			xEnd    <= x2[xBits-1:0];
			yEnd    <= y2[yBits-1:0];
			pixByte <= colour[7:0];
		end
		if (state == stateDispatch) begin
			lineVertical      <= (cmd == vLine);
			ColourPaletteAddr <= colour[paletteAddrBits-1:0];	// palette entry number
			ColourPaletteData <= {x1[7:0], y1};				// red from x1, green and blue from y1
		end
		if ((state == stateDrawLine) && !lineDone) begin
			if (lineVertical)
				yCnt <= yCnt + 1'b1;
			else
				xCnt <= xCnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// frame buffer requests
	////////////////////////////////////////

	// a request goes out in every cycle of these states with no handshake back
	assign fb.reqValid = (state == stateWritePixel) || (state == stateDrawLine) ||
		(state == stateReadIssue);
	assign fb.reqWrite = (state != stateReadIssue);
	assign fb.reqAddr  = {yCnt, xCnt[xBits-1:1]};	// two pixels share each word
	assign fb.reqUpper = ~xCnt[0];		// even x lives in the upper byte
	assign fb.reqLower = xCnt[0];
	assign fb.reqData  = {pixByte, pixByte};	// the strobe picks which half lands

	// the returned byte goes straight to the colour latch in hostRegs
	assign latchLoad = (state == stateReadWait) && fb.rdValid;
	assign latchByte = fb.rdByte;

endmodule

`default_nettype wire

// ==== hdl/hostRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

module hostRegs import gfxPkg::*; (
	input  logic     Clk,
	input  logic     rst,
	input  busWord_t AddressIn,
	input  busWord_t DataInFromCPU,
	input  logic     AS_L,
	input  logic     UDS_L,
	input  logic     LDS_L,
	input  logic     RW,
	input  logic     GraphicsCS_L,
	input  logic     idle,			// status bit from the sequencer
	input  logic     latchLoad,		// the sequencer returns a pixel byte
	input  logic [7:0] latchByte,
	output busWord_t DataOutToCPU,
	output busWord_t x1,
	output busWord_t y1,
	output busWord_t x2,
	output busWord_t y2,
	output busWord_t colour,
	output gfxCmd_t  cmd,
	output logic     cmdStart
);

	logic       regWrite;		// a CPU write cycle aimed at this block
	logic       regRead;		// a CPU read cycle aimed at this block
	logic [6:0] regOffset;		// word offset within the register map
	logic       cmdSel;			// the write is to the command register
	logic       cmdWritten;		// a command was written and the strobe has not ended yet
	busWord_t   cmdReg;
	busWord_t   colourLatch;	// last byte returned by get pixel

	// only lanes whose strobe is low take the new byte
	function automatic busWord_t byteMerge(
		input busWord_t oldWord,
		input busWord_t newWord,
		input logic     upperL,
		input logic     lowerL
	);
		busWord_t merged;
		merged = oldWord;
		if (!upperL)
			merged[15:8] = newWord[15:8];
		if (!lowerL)
			merged[7:0] = newWord[7:0];
		return merged;
	endfunction

	////////////////////////////////////////
	// bus decode
	////////////////////////////////////////

	assign regOffset = AddressIn[7:1];	// byte address bit 0 is ignored
	assign regWrite  = !GraphicsCS_L && !AS_L && !RW && (AddressIn[15:8] == 8'h00);
	assign regRead   = !GraphicsCS_L && !AS_L && RW && (AddressIn[15:8] == 8'h00);
	assign cmdSel    = regWrite && (regOffset == regCommandOffset);

	////////////////////////////////////////
	// register file
	////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (rst) begin
			x1     <= '0;
			y1     <= '0;
			x2     <= x2ResetValue;
			y2     <= y2ResetValue;
			colour <= colourResetValue;
			cmdReg <= '0;
		end else if (regWrite) begin
			// the write repeats on every edge of the bus cycle, which is harmless
			case (regOffset)
				regCommandOffset: cmdReg <= byteMerge(cmdReg, DataInFromCPU, UDS_L, LDS_L);
				regX1Offset:      x1     <= byteMerge(x1, DataInFromCPU, UDS_L, LDS_L);
				regY1Offset:      y1     <= byteMerge(y1, DataInFromCPU, UDS_L, LDS_L);
				regX2Offset:      x2     <= byteMerge(x2, DataInFromCPU, UDS_L, LDS_L);
				regY2Offset:      y2     <= byteMerge(y2, DataInFromCPU, UDS_L, LDS_L);
				regColourOffset:  colour <= byteMerge(colour, DataInFromCPU, UDS_L, LDS_L);
				default: ;	// writes to unmapped offsets are dropped
			endcase
		end
	end

	assign cmd = gfxCmd_t'(cmdReg);	// unknown codes pass through and the sequencer ignores them

	// the command starts only once the CPU has released the address strobe
	always_ff @(posedge Clk) begin
		if (rst) begin
			cmdWritten <= 1'b0;
			cmdStart   <= 1'b0;
		end else begin
			cmdStart <= cmdWritten && AS_L;	// one cycle pulse on the first edge with AS_L high
			if (cmdSel)
				cmdWritten <= 1'b1;
			else if (AS_L)
				cmdWritten <= 1'b0;
		end
	end

	////////////////////////////////////////
	// colour latch and read bus
	////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (latchLoad)
			colourLatch <= {8'h00, latchByte};	// a pixel is one byte so the top half reads zero
	end

	// reads are combinational and the bus reads zero outside a read cycle
	always_comb begin
		DataOutToCPU = '0;
		if (regRead) begin
			case (regOffset)
				regCommandOffset: DataOutToCPU = {15'd0, idle};	// status, bit 0 set when idle
				regColourOffset:  DataOutToCPU = colourLatch;
				default:          DataOutToCPU = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/frameBufferIf.sv ====
`timescale 1ns/1ns
`default_nettype none

interface frameBufferIf import gfxPkg::*; #(
	parameter int xBits = 10,
	parameter int yBits = 9
);

	// two pixels per word so the x part of the address loses its low bit
	localparam int addrBits = xBits - 1 + yBits;

	logic                reqValid;	// one SRAM access in this cycle, always accepted
	logic                reqWrite;	// high for a write and low for a read
	logic [addrBits-1:0] reqAddr;	// y bits followed by x bits without the low one
	logic                reqUpper;	// upper byte lane, also picks the read byte
	logic                reqLower;	// lower byte lane
	busWord_t            reqData;	// the pixel byte is copied to both halves

	logic                rdValid;	// one cycle pulse with the returned byte
	logic [7:0]          rdByte;

	modport seq (
		output reqValid, reqWrite, reqAddr, reqUpper, reqLower, reqData,
		input  rdValid, rdByte
	);

	modport port (
		input  reqValid, reqWrite, reqAddr, reqUpper, reqLower, reqData,
		output rdValid, rdByte
	);

endinterface

`default_nettype wire

// ==== hdl/gfxPkg.sv ====
`default_nettype none

package gfxPkg;

	////////////////////////////////////////
	// bus and register words
	////////////////////////////////////////

	// every CPU visible register and the SRAM data bus are one 16 bit word
	typedef logic [15:0] busWord_t;

	// command codes written by the CPU into the command register
	typedef enum logic [15:0] {
		hLine          = 16'h0001,	// horizontal line from x1 to x2 at y1
		vLine          = 16'h0002,	// vertical line from y1 to y2 at x1
		putPixel       = 16'h000A,	// one pixel at x1,y1
		getPixel       = 16'h000B,	// read one pixel into the colour latch
		programPalette = 16'h0010	// load one palette entry during vertical sync
	} gfxCmd_t;

	////////////////////////////////////////
	// register map
	////////////////////////////////////////

	// word offsets taken from address bits 7 to 1
	localparam logic [6:0] regCommandOffset = 7'd0;	// the status register reads back here
	localparam logic [6:0] regX1Offset      = 7'd1;
	localparam logic [6:0] regY1Offset      = 7'd2;
	localparam logic [6:0] regX2Offset      = 7'd3;
	localparam logic [6:0] regY2Offset      = 7'd4;
	localparam logic [6:0] regColourOffset  = 7'd7;	// the colour latch reads back here

	// x2 and y2 come out of reset at the full screen size
	localparam busWord_t x2ResetValue     = 16'd1024;
	localparam busWord_t y2ResetValue     = 16'd512;
	localparam busWord_t colourResetValue = 16'd4;	// palette entry 4 so a cleared screen is blue

	// 64 palette entries of 24 bit RGB
	localparam int paletteAddrBits = 6;
	localparam int paletteDataBits = 24;

	////////////////////////////////////////
	// sequencer states
	////////////////////////////////////////

	typedef enum logic [2:0] {
		stateIdle,			// waiting for a command start
		stateDispatch,		// decode the command that was just written
		stateWritePixel,	// one write request for put pixel
		stateDrawLine,		// one write request per clock until the end coordinate
		stateReadIssue,		// one read request for get pixel
		stateReadWait,		// wait for the port to return the byte
		statePaletteWait	// hold off until vertical sync is active
	} seqState_t;

endpackage

`default_nettype wire
